// ==== include/enigma_defines.svh ====
`ifndef ENIGMA_DEFINES_SVH
`define ENIGMA_DEFINES_SVH

// ====================
// engine geometry
// ====================

// symbol and rotor index width
`define ENIGMA_CODE_W 6

// entries per rotor
`define ENIGMA_DEPTH 64

// permute rotor reorders in groups of this size
`define ENIGMA_GROUP 8

// one burst loads both rotors back to back
`define ENIGMA_LOAD_LEN 128

`endif

// ==== verilog/enigma_pkg.sv ====
`include "enigma_defines.svh"

package enigma_pkg;

	// one symbol, or one rotor index
	typedef logic [`ENIGMA_CODE_W-1:0] code_t;

	typedef enum logic {
		encrypt = 1'b0,
		decrypt = 1'b1
	} crypt_mode_e;

	typedef enum logic [1:0] {
		idle  = 2'd0,
		load  = 2'd1,
		crypt = 2'd2
	} ctrl_state_e;

	// rotor value seen as step controls
	typedef struct packed {
		logic [`ENIGMA_CODE_W-3:0] upper;
		logic [1:0]                shift_amt;
	} shift_view_t;

	typedef struct packed {
		logic [`ENIGMA_CODE_W-4:0] upper;
		logic [2:0]                perm_mode;
	} perm_view_t;

	typedef union packed {
		shift_view_t as_shift;
		perm_view_t  as_perm;
	} rotor_word_u;

endpackage

// ==== verilog/enigma_ctrl.sv ====
`timescale 1ns/1ps
`include "enigma_defines.svh"

module enigma_ctrl (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  logic                    in_valid_2,
	input  enigma_pkg::crypt_mode_e crypt_mode,
	output logic                    load_a_en,
	output logic                    load_b_en,
	output enigma_pkg::code_t       load_idx,
	output logic                    sym_en,
	output enigma_pkg::crypt_mode_e mode
);

	localparam int CNT_W = $clog2(`ENIGMA_LOAD_LEN + 1);

	enigma_pkg::ctrl_state_e state;
	enigma_pkg::ctrl_state_e state_nxt;
	logic [CNT_W-1:0]        cnt;
	logic                    burst_start;

	// ====================
	// load burst counter
	// ====================

	assign burst_start = in_valid && (cnt == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (!in_valid) begin
			cnt <= '0;
		end else if (cnt != CNT_W'(`ENIGMA_LOAD_LEN)) begin
			cnt <= cnt + 1'b1;
		end
	end

	// first half fills the shift rotor, second half the permute rotor
	assign load_a_en = in_valid && (cnt < CNT_W'(`ENIGMA_DEPTH));
	assign load_b_en = in_valid && (cnt >= CNT_W'(`ENIGMA_DEPTH)) &&
		(cnt < CNT_W'(`ENIGMA_LOAD_LEN));
	assign load_idx  = cnt[`ENIGMA_CODE_W-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode <= enigma_pkg::encrypt;
		end else if (burst_start) begin
			mode <= crypt_mode;
		end
	end

	// ====================
	// state machine
	// ====================

	// a symbol in load state already counts
	assign sym_en = in_valid_2 && !in_valid &&
		((state == enigma_pkg::load) || (state == enigma_pkg::crypt));

	always_comb begin
		state_nxt = state;
		case (state)
			enigma_pkg::idle: if (in_valid) state_nxt = enigma_pkg::load;
			enigma_pkg::load: if (sym_en) state_nxt = enigma_pkg::crypt;
			enigma_pkg::crypt: if (in_valid) state_nxt = enigma_pkg::load;
			default: state_nxt = enigma_pkg::idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= enigma_pkg::idle;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

// ==== verilog/shift_rotor.sv ====
`timescale 1ns/1ps
`include "enigma_defines.svh"

module shift_rotor (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    load_en,
	input  enigma_pkg::code_t       load_idx,
	input  enigma_pkg::code_t       code_in,
	input  enigma_pkg::code_t       b_inv,
	input  logic                    step_en,
	input  logic [1:0]              shift_amt,
	output enigma_pkg::rotor_word_u a_fwd,
	output enigma_pkg::code_t       a_inv
);

	enigma_pkg::code_t rotor [`ENIGMA_DEPTH];

	// ====================
	// table update
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < `ENIGMA_DEPTH; k++) begin
				rotor[k] <= '0;
			end
		end else if (load_en) begin
			rotor[load_idx] <= code_in;
		end else if (step_en) begin
			// whole table rotates up by shift_amt, wrapping at the top
			for (int k = 0; k < `ENIGMA_DEPTH; k++) begin
				rotor[(k + int'(shift_amt)) % `ENIGMA_DEPTH] <= rotor[k];
			end
		end
	end

	// ====================
	// lookups
	// ====================

	// forward path, first stage of the chain
	assign a_fwd = rotor[code_in];

	// inverse path, last stage of the chain
	// scan from the top so the lowest match is the one kept
	always_comb begin
		a_inv = '0;
		for (int k = `ENIGMA_DEPTH - 1; k >= 0; k--) begin
			if (rotor[k] == b_inv) begin
				a_inv = enigma_pkg::code_t'(k);
			end
		end
	end

endmodule

// ==== verilog/perm_rotor.sv ====
`timescale 1ns/1ps
`include "enigma_defines.svh"

module perm_rotor (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    load_en,
	input  enigma_pkg::code_t       load_idx,
	input  enigma_pkg::code_t       code_in,
	input  enigma_pkg::code_t       a_fwd,
	input  enigma_pkg::code_t       refl,
	input  logic                    step_en,
	input  logic [2:0]              perm_mode,
	output enigma_pkg::rotor_word_u b_fwd,
	output enigma_pkg::code_t       b_inv
);

	localparam int NUM_GROUPS = `ENIGMA_DEPTH / `ENIGMA_GROUP;

	// source slot inside a group, indexed [mode][new slot]
	localparam logic [0:7][0:`ENIGMA_GROUP-1][2:0] PERM_SRC = {
		{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7},
		{3'd1, 3'd0, 3'd3, 3'd2, 3'd5, 3'd4, 3'd7, 3'd6},
		{3'd2, 3'd3, 3'd0, 3'd1, 3'd6, 3'd7, 3'd4, 3'd5},
		{3'd0, 3'd4, 3'd5, 3'd6, 3'd1, 3'd2, 3'd3, 3'd7},
		{3'd4, 3'd5, 3'd6, 3'd7, 3'd0, 3'd1, 3'd2, 3'd3},
		{3'd5, 3'd6, 3'd7, 3'd3, 3'd4, 3'd0, 3'd1, 3'd2},
		{3'd6, 3'd7, 3'd3, 3'd2, 3'd5, 3'd4, 3'd0, 3'd1},
		{3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0}
	};

	enigma_pkg::code_t rotor [`ENIGMA_DEPTH];

	// ====================
	// table update
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < `ENIGMA_DEPTH; k++) begin
				rotor[k] <= '0;
			end
		end else if (load_en) begin
			rotor[load_idx] <= code_in;
		end else if (step_en) begin
			// every group of 8 gets the same shuffle
			for (int g = 0; g < NUM_GROUPS; g++) begin
				for (int i = 0; i < `ENIGMA_GROUP; i++) begin
					rotor[g * `ENIGMA_GROUP + i] <=
						rotor[g * `ENIGMA_GROUP + int'(PERM_SRC[perm_mode][i])];
				end
			end
		end
	end

	// ====================
	// lookups
	// ====================

	// second stage, fed by the shift rotor
	assign b_fwd = rotor[a_fwd];

	// fourth stage, undoes the reflector side
	always_comb begin
		b_inv = '0;
		for (int k = `ENIGMA_DEPTH - 1; k >= 0; k--) begin
			if (rotor[k] == refl) begin
				b_inv = enigma_pkg::code_t'(k);
			end
		end
	end

endmodule

// ==== verilog/cipher_core.sv ====
`timescale 1ns/1ps
`include "enigma_defines.svh"

module cipher_core (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    sym_en,
	input  enigma_pkg::crypt_mode_e mode,
	input  enigma_pkg::rotor_word_u a_fwd,
	input  enigma_pkg::rotor_word_u b_fwd,
	input  enigma_pkg::code_t       b_inv,
	input  enigma_pkg::code_t       a_inv,
	output enigma_pkg::code_t       refl,
	output logic [1:0]              shift_amt,
	output logic [2:0]              perm_mode,
	output logic                    out_valid,
	output enigma_pkg::code_t       out_code
);

	enigma_pkg::rotor_word_u refl_w;
	enigma_pkg::rotor_word_u b_inv_w;

	// reflector
	assign refl = enigma_pkg::code_t'(`ENIGMA_DEPTH - 1) - enigma_pkg::code_t'(b_fwd);

	assign refl_w  = refl;
	assign b_inv_w = b_inv;

	// ====================
	// step controls
	// ====================

	// decrypt taps the mirror points of the chain, so both
	// directions step the rotors identically
	always_comb begin
		if (mode == enigma_pkg::decrypt) begin
			shift_amt = b_inv_w.as_shift.shift_amt;
			perm_mode = refl_w.as_perm.perm_mode;
		end else begin
			shift_amt = a_fwd.as_shift.shift_amt;
			perm_mode = b_fwd.as_perm.perm_mode;
		end
	end

	// ====================
	// output stage
	// ====================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_code  <= '0;
		end else begin
			out_valid <= sym_en;
			out_code  <= sym_en ? a_inv : '0;
		end
	end

endmodule

// ==== verilog/enigma_top.sv ====
`timescale 1ns/1ps

module enigma_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  logic                    in_valid_2,
	input  enigma_pkg::crypt_mode_e crypt_mode,
	input  enigma_pkg::code_t       code_in,
	output logic                    out_valid,
	output enigma_pkg::code_t       out_code
);

	logic                    load_a_en;
	logic                    load_b_en;
	enigma_pkg::code_t       load_idx;
	logic                    sym_en;
	enigma_pkg::crypt_mode_e mode;

	enigma_pkg::rotor_word_u a_fwd;
	enigma_pkg::code_t       a_inv;
	enigma_pkg::rotor_word_u b_fwd;
	enigma_pkg::code_t       b_inv;
	enigma_pkg::code_t       refl;
	logic [1:0]              shift_amt;
	logic [2:0]              perm_mode;

	enigma_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_valid_2 (in_valid_2),
		.crypt_mode (crypt_mode),
		.load_a_en  (load_a_en),
		.load_b_en  (load_b_en),
		.load_idx   (load_idx),
		.sym_en     (sym_en),
		.mode       (mode)
	);

	shift_rotor u_shift (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_en   (load_a_en),
		.load_idx  (load_idx),
		.code_in   (code_in),
		.b_inv     (b_inv),
		.step_en   (sym_en),
		.shift_amt (shift_amt),
		.a_fwd     (a_fwd),
		.a_inv     (a_inv)
	);

	perm_rotor u_perm (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_en   (load_b_en),
		.load_idx  (load_idx),
		.code_in   (code_in),
		.a_fwd     (a_fwd),
		.refl      (refl),
		.step_en   (sym_en),
		.perm_mode (perm_mode),
		.b_fwd     (b_fwd),
		.b_inv     (b_inv)
	);

	cipher_core u_core (
		.clk       (clk),
		.rst_n     (rst_n),
		.sym_en    (sym_en),
		.mode      (mode),
		.a_fwd     (a_fwd),
		.b_fwd     (b_fwd),
		.b_inv     (b_inv),
		.a_inv     (a_inv),
		.refl      (refl),
		.shift_amt (shift_amt),
		.perm_mode (perm_mode),
		.out_valid (out_valid),
		.out_code  (out_code)
	);

endmodule

// ==== tests/enigma_ref.svh ====
`ifndef ENIGMA_REF_SVH
`define ENIGMA_REF_SVH

// ====================
// cipher model
// ====================

// source slot for each new slot, one row per permutation mode
localparam int REF_SRC [8][8] = '{
	'{0, 1, 2, 3, 4, 5, 6, 7},
	'{1, 0, 3, 2, 5, 4, 7, 6},
	'{2, 3, 0, 1, 6, 7, 4, 5},
	'{0, 4, 5, 6, 1, 2, 3, 7},
	'{4, 5, 6, 7, 0, 1, 2, 3},
	'{5, 6, 7, 3, 4, 0, 1, 2},
	'{6, 7, 3, 2, 5, 4, 0, 1},
	'{7, 6, 5, 4, 3, 2, 1, 0}
};

enigma_pkg::code_t ref_a [`ENIGMA_DEPTH];
enigma_pkg::code_t ref_b [`ENIGMA_DEPTH];

// lowest matching index, 0 when nothing matches
function automatic enigma_pkg::code_t ref_find(input enigma_pkg::code_t tbl [`ENIGMA_DEPTH],
	input enigma_pkg::code_t val);
	for (int k = 0; k < `ENIGMA_DEPTH; k++) begin
		if (tbl[k] == val) begin
			return enigma_pkg::code_t'(k);
		end
	end
	return '0;
endfunction

// one symbol through the chain, then both rotors step
function automatic enigma_pkg::code_t ref_symbol(input enigma_pkg::code_t sym,
	input enigma_pkg::crypt_mode_e m);
	enigma_pkg::code_t a;
	enigma_pkg::code_t b;
	enigma_pkg::code_t r;
	enigma_pkg::code_t bi;
	enigma_pkg::code_t ai;
	enigma_pkg::code_t old_a [`ENIGMA_DEPTH];
	enigma_pkg::code_t old_b [`ENIGMA_DEPTH];
	int sa;
	int pm;
	a = ref_a[sym];
	b = ref_b[a];
	r = enigma_pkg::code_t'((`ENIGMA_DEPTH - 1) - int'(b));
	bi = ref_find(ref_b, r);
	ai = ref_find(ref_a, bi);
	sa = (m == enigma_pkg::encrypt) ? int'(a) % 4 : int'(bi) % 4;
	pm = (m == enigma_pkg::encrypt) ? int'(b) % 8 : int'(r) % 8;
	old_a = ref_a;
	old_b = ref_b;
	for (int k = 0; k < `ENIGMA_DEPTH; k++) begin
		ref_a[(k + sa) % `ENIGMA_DEPTH] = old_a[k];
		ref_b[k] = old_b[k - k % `ENIGMA_GROUP + REF_SRC[pm][k % `ENIGMA_GROUP]];
	end
	return ai;
endfunction

`endif

// ==== tests/enigma_tb.sv ====
`timescale 1ns/1ps
`include "enigma_defines.svh"

module enigma_tb;

	typedef struct packed {
		enigma_pkg::crypt_mode_e mode;
		logic [31:0]             seed;
		logic [7:0]              len;
		logic [7:0]              gaps;
		logic                    round_trip;
	} row_t;

	localparam int NUM_ROWS = 6;

	// mode, rotor seed, length, idle mask, round trip
	localparam row_t ROWS [NUM_ROWS] = '{
		'{enigma_pkg::encrypt, 32'h0000_1234, 8'd24, 8'h00, 1'b0},
		'{enigma_pkg::decrypt, 32'h0000_5a5a, 8'd24, 8'h00, 1'b0},
		'{enigma_pkg::encrypt, 32'h0000_0bad, 8'd32, 8'h00, 1'b1},
		'{enigma_pkg::encrypt, 32'h0000_1234, 8'd24, 8'ha6, 1'b0},
		'{enigma_pkg::decrypt, 32'h0000_7777, 8'd10, 8'h00, 1'b0},
		'{enigma_pkg::encrypt, 32'h0000_4242, 8'd24, 8'h11, 1'b1}
	};

	logic                    clk;
	logic                    rst_n;
	logic                    in_valid;
	logic                    in_valid_2;
	enigma_pkg::crypt_mode_e crypt_mode;
	enigma_pkg::code_t       code_in;
	logic                    out_valid;
	enigma_pkg::code_t       out_code;

	logic                    exp_valid;
	enigma_pkg::code_t       exp_code;
	enigma_pkg::code_t       results [$];
	logic [31:0]             lcg;
	int                      row_no;
	int                      sym_no;
	int                      errors;
	int                      rows_failed;

	initial clk = 1'b0;
	always #4 clk = ~clk;

	enigma_top u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_valid_2 (in_valid_2),
		.crypt_mode (crypt_mode),
		.code_in    (code_in),
		.out_valid  (out_valid),
		.out_code   (out_code)
	);

	`include "enigma_ref.svh"

	task automatic check_code(input enigma_pkg::code_t got, input enigma_pkg::code_t exp,
		input string what);
		if (got !== exp) begin
			$display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_valid(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	function automatic int unsigned lcg_next();
		lcg = lcg * 32'd1103515245 + 32'd12345;
		return {16'd0, lcg[31:16]};
	endfunction

	// checks the previous cycle's output, then applies the new inputs
	task automatic drive(input logic iv, input logic iv2, input enigma_pkg::crypt_mode_e m,
		input enigma_pkg::code_t c);
		@(negedge clk);
		if (exp_valid && !out_valid) begin
			$display("row %0d: symbol %0d produced no output", row_no, sym_no);
			errors++;
		end else begin
			check_valid(out_valid, exp_valid, "out_valid");
			if (exp_valid) begin
				check_code(out_code, exp_code, "out_code");
			end
		end
		if (exp_valid) begin
			results.push_back(out_code);
		end
		exp_valid = 1'b0;
		in_valid = iv;
		in_valid_2 = iv2;
		crypt_mode = m;
		code_in = c;
	endtask

	// two shuffled permutations of 0..63 from one seed
	task automatic build_rotors(input logic [31:0] seed);
		int j;
		enigma_pkg::code_t t;
		lcg = seed;
		for (int k = 0; k < `ENIGMA_DEPTH; k++) begin
			ref_a[k] = enigma_pkg::code_t'(k);
			ref_b[k] = enigma_pkg::code_t'(k);
		end
		for (int k = `ENIGMA_DEPTH - 1; k > 0; k--) begin
			j = lcg_next() % (k + 1);
			t = ref_a[k];
			ref_a[k] = ref_a[j];
			ref_a[j] = t;
			j = lcg_next() % (k + 1);
			t = ref_b[k];
			ref_b[k] = ref_b[j];
			ref_b[j] = t;
		end
	endtask

	task automatic load_rotors(input enigma_pkg::crypt_mode_e m);
		enigma_pkg::crypt_mode_e other;
		enigma_pkg::code_t       c;
		other = (m == enigma_pkg::encrypt) ? enigma_pkg::decrypt : enigma_pkg::encrypt;
		for (int k = 0; k < `ENIGMA_LOAD_LEN; k++) begin
			c = (k < `ENIGMA_DEPTH) ? ref_a[k] : ref_b[k - `ENIGMA_DEPTH];
			// later cycles carry the wrong mode and stray symbol strobes
			drive(1'b1, 1'($urandom), (k == 0) ? m : other, c);
			if (row_no == 0) begin
				check_code(out_code, '0, "out_code before first symbol");
			end
		end
	endtask

	task automatic send_message(input enigma_pkg::crypt_mode_e m,
		input enigma_pkg::code_t msg [$], input logic [7:0] gaps);
		results.delete();
		for (int i = 0; i < msg.size(); i++) begin
			if (gaps[i % 8]) begin
				drive(1'b0, 1'b0, m, enigma_pkg::code_t'($urandom));
			end
			drive(1'b0, 1'b1, m, msg[i]);
			exp_code = ref_symbol(msg[i], m);
			exp_valid = 1'b1;
			sym_no = i;
		end
		drive(1'b0, 1'b0, m, '0);
	endtask

	// ====================
	// main sequence
	// ====================

	initial begin
		enigma_pkg::code_t plain [$];
		enigma_pkg::code_t cipher [$];
		int                start_errors;
		void'($urandom(32'h7b9));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_valid_2 = 1'b0;
		crypt_mode = enigma_pkg::encrypt;
		code_in = '0;
		exp_valid = 1'b0;
		exp_code = '0;
		row_no = -1;
		sym_no = 0;
		errors = 0;
		rows_failed = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		check_valid(out_valid, 1'b0, "out_valid in reset");
		check_code(out_code, '0, "out_code in reset");
		rst_n = 1'b1;
		// symbol strobes while idle
		repeat (4) begin
			drive(1'b0, 1'b1, enigma_pkg::encrypt, enigma_pkg::code_t'($urandom));
		end
		for (int r = 0; r < NUM_ROWS; r++) begin
			row_no = r;
			start_errors = errors;
			build_rotors(ROWS[r].seed);
			plain.delete();
			for (int i = 0; i < ROWS[r].len; i++) begin
				plain.push_back(enigma_pkg::code_t'(lcg_next()));
			end
			load_rotors(ROWS[r].mode);
			send_message(ROWS[r].mode, plain, ROWS[r].gaps);
			if (ROWS[r].round_trip) begin
				cipher = results;
				build_rotors(ROWS[r].seed);
				load_rotors(enigma_pkg::decrypt);
				send_message(enigma_pkg::decrypt, cipher, 8'h00);
				for (int i = 0; i < plain.size() && i < results.size(); i++) begin
					check_code(results[i], plain[i], "round trip symbol");
				end
			end
			if (errors != start_errors) begin
				rows_failed++;
			end
			$display("row %0d: %s, %0d symbols, state %s, %s", r,
				(ROWS[r].mode == enigma_pkg::decrypt) ? "decrypt" : "encrypt",
				ROWS[r].len, u_dut.u_ctrl.state.name(),
				(errors == start_errors) ? "ok" : "mismatch");
		end
		$display("%0d rows run, %0d failed, %0d errors", NUM_ROWS, rows_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// watchdog sized from the table
	initial begin
		int unsigned cycles;
		cycles = 16;
		for (int r = 0; r < NUM_ROWS; r++) begin
			cycles += `ENIGMA_LOAD_LEN + ROWS[r].len + 1;
			for (int i = 0; i < ROWS[r].len; i++) begin
				cycles += ROWS[r].gaps[i % 8];
			end
			if (ROWS[r].round_trip) begin
				cycles += `ENIGMA_LOAD_LEN + ROWS[r].len + 1;
			end
		end
		#(2 * cycles * 8);
		$display("watchdog expired at %0t, the run did not finish in time", $time);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+include
+incdir+tests
verilog/enigma_pkg.sv
verilog/enigma_ctrl.sv
verilog/shift_rotor.sv
verilog/perm_rotor.sv
verilog/cipher_core.sv
verilog/enigma_top.sv
tests/enigma_tb.sv

// ==== Bender.yml ====
package:
  name: enigma

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/enigma_pkg.sv
      - verilog/enigma_ctrl.sv
      - verilog/shift_rotor.sv
      - verilog/perm_rotor.sv
      - verilog/cipher_core.sv
      - verilog/enigma_top.sv
  - target: test
    include_dirs:
      - include
      - tests
    files:
      - tests/enigma_tb.sv
